//--- source/ex_macros.svh
// ########################################
// Width macros for the execute pipe
// Data, PC, register, ROB id, fault code
// ########################################

`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Data path width
`define EX_DW 32

// Word PC, byte address is PC followed by 2'b00
`define EX_PC_W 30

// Physical register file address
`define EX_PRF_AW 6

// Reorder buffer id
`define EX_ROB_AW 5

// Fetch fault code, zero when fetch was clean
`define EX_FE_W 4

`endif

//--- source/ex_pkg.sv
// ########################################
// Execute pipe types
// Unit and opcode enums, opcode union,
// request and writeback records
// ########################################

`include "ex_macros.svh"

package ex_pkg;

   // Functional unit select
   typedef enum logic [1:0] {
      UNIT_ALU = 2'd0,
      UNIT_BRU = 2'd1,
      UNIT_LSU = 2'd2,
      UNIT_EPU = 2'd3
   } ex_unit_e;

   // Integer ALU ops
   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_SLL  = 4'd5,
      ALU_SRL  = 4'd6,
      ALU_SRA  = 4'd7,
      ALU_SLT  = 4'd8,
      ALU_SLTU = 4'd9,
      ALU_MOVI = 4'd10
   } ex_alu_op_e;

   // Branch ops, jal is pc-relative and jalr goes through a register
   typedef enum logic [3:0] {
      BRU_BEQ  = 4'd0,
      BRU_BNE  = 4'd1,
      BRU_BLT  = 4'd2,
      BRU_BGE  = 4'd3,
      BRU_BLTU = 4'd4,
      BRU_BGEU = 4'd5,
      BRU_JAL  = 4'd6,
      BRU_JALR = 4'd7
   } ex_bru_op_e;

   // One opcode word, read by the unit that the op goes to
   typedef union packed {
      ex_alu_op_e alu;
      ex_bru_op_e bru;
   } ex_op_u;

   typedef struct packed {
      ex_unit_e                unit;
      ex_op_u                  op;
      logic [`EX_FE_W-1:0]     fe;
      logic                    pred_taken;
      logic [`EX_PC_W-1:0]     pred_tgt;
      logic [`EX_PC_W-1:0]     pc;
      logic [`EX_DW-1:0]       imm;
      logic [`EX_DW-1:0]       operand1;
      logic [`EX_DW-1:0]       operand2;
      logic [`EX_PRF_AW-1:0]   prd;
      logic                    prd_we;
      logic [`EX_ROB_AW-1:0]   rob_id;
   } ex_req_t;

   typedef struct packed {
      logic [`EX_ROB_AW-1:0]   rob_id;
      logic                    prf_we;
      logic [`EX_PRF_AW-1:0]   prf_waddr;
      logic [`EX_DW-1:0]       prf_wdata;
      logic                    fls;
      logic                    exc;
      logic [`EX_DW-1:0]       opera;
      logic [`EX_DW-1:0]       operb;
   } ex_wb_t;

endpackage

//--- source/ex_alu.sv
// ########################################
// Integer ALU of the execute pipe
// Arithmetic, logic, shift and compare
// ########################################

`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_alu
   import ex_pkg::*;
(
   input  ex_alu_op_e          op,
   input  logic [`EX_DW-1:0]   operand1,
   input  logic [`EX_DW-1:0]   operand2,
   input  logic [`EX_DW-1:0]   imm,
   input  logic [`EX_DW-1:0]   add_sum,
   input  logic                carry,
   input  logic                overflow,
   output logic [`EX_DW-1:0]   alu_result
);

   localparam int SHW = $clog2(`EX_DW);

   logic [SHW-1:0]      shamt;
   logic [`EX_DW-1:0]   sll_res;
   logic [`EX_DW-1:0]   srl_res;
   logic [`EX_DW-1:0]   sra_res;
   logic                slt_res;
   logic                sltu_res;

   // Shift amount from the low bits of operand2
   assign shamt = operand2[SHW-1:0];

   assign sll_res = operand1 << shamt;
   assign srl_res = operand1 >> shamt;
   assign sra_res = $unsigned($signed(operand1) >>> shamt);

   // Compares reuse the subtract in the shared adder
   // Signed less-than is sign of the difference corrected by overflow
   assign slt_res = add_sum[`EX_DW-1] ^ overflow;

   // No carry out of a - b means a borrow, so a < b unsigned
   assign sltu_res = ~carry;

   always_comb begin
      case (op)
         ALU_ADD,
         ALU_SUB: begin
            alu_result = add_sum;
         end
         ALU_AND:  alu_result = operand1 & operand2;
         ALU_OR:   alu_result = operand1 | operand2;
         ALU_XOR:  alu_result = operand1 ^ operand2;
         ALU_SLL:  alu_result = sll_res;
         ALU_SRL:  alu_result = srl_res;
         ALU_SRA:  alu_result = sra_res;
         ALU_SLT: begin
            alu_result = {{(`EX_DW-1){1'b0}}, slt_res};
         end
         ALU_SLTU: begin
            alu_result = {{(`EX_DW-1){1'b0}}, sltu_res};
         end
         // Immediate move
         ALU_MOVI: alu_result = imm;
         default: begin
            alu_result = '0;
         end
      endcase
   end

endmodule

//--- source/ex_bru.sv
// ########################################
// Branch unit of the execute pipe
// Condition, target and link value
// ########################################

`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_bru
   import ex_pkg::*;
(
   input  ex_bru_op_e            op,
   input  logic [`EX_PC_W-1:0]   pc,
   input  logic [`EX_PC_W-1:0]   npc,
   input  logic [`EX_DW-1:0]     imm,
   input  logic [`EX_DW-1:0]     operand1,
   input  logic [`EX_DW-1:0]     add_sum,
   input  logic                  carry,
   input  logic                  overflow,
   output logic                  taken,
   output logic [`EX_PC_W-1:0]   tgt,
   output logic [`EX_DW-1:0]     link
);

   logic                  cmp_eq;
   logic                  cmp_lt;
   logic                  cmp_ltu;
   logic [`EX_PC_W-1:0]   rel_tgt;
   logic [`EX_PC_W-1:0]   reg_tgt;

   // Flags of operand1 - operand2 from the shared adder
   assign cmp_eq  = (add_sum == '0);
   assign cmp_lt  = add_sum[`EX_DW-1] ^ overflow;
   assign cmp_ltu = ~carry;

   always_comb begin
      case (op)
         BRU_BEQ:  taken = cmp_eq;
         BRU_BNE:  taken = ~cmp_eq;
         BRU_BLT:  taken = cmp_lt;
         BRU_BGE:  taken = ~cmp_lt;
         BRU_BLTU: taken = cmp_ltu;
         BRU_BGEU: taken = ~cmp_ltu;
         // Jumps always go
         BRU_JAL,
         BRU_JALR: begin
            taken = 1'b1;
         end
         default: begin
            taken = 1'b0;
         end
      endcase
   end

   // Word offset in imm, added to the word PC
   assign rel_tgt = pc + imm[`EX_PC_W-1:0];

   // Register jump drops the byte offset bits
   assign reg_tgt = operand1[`EX_DW-1:`EX_DW-`EX_PC_W];

   always_comb begin
      if (op == BRU_JALR) begin
         tgt = reg_tgt;
      end else begin
         tgt = rel_tgt;
      end
   end

   // Return address as a byte address
   assign link = {npc, 2'b00};

endmodule

//--- source/ex_out_buf.sv
// ########################################
// One-entry valid/ready output stage
// with flush toward writeback
// ########################################

`timescale 1ns/1ps

module ex_out_buf
   import ex_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     flush,
   input  logic     in_valid,
   input  logic     out_ready,
   input  ex_wb_t   in_data,
   output logic     in_ready,
   output logic     out_valid,
   output logic     load,
   output ex_wb_t   out_data
);

   ex_wb_t   data_q;
   logic     valid_q;
   logic     we_q;
   logic     fls_q;
   logic     exc_q;

   // Room when empty or when the held record leaves this cycle
   assign in_ready = ~valid_q | out_ready;
   assign load     = in_valid & in_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= 1'b0;
         we_q    <= 1'b0;
         fls_q   <= 1'b0;
         exc_q   <= 1'b0;
      end else if (flush) begin
         // Flush drops the entry even if a load comes in
         valid_q <= 1'b0;
         we_q    <= 1'b0;
         fls_q   <= 1'b0;
         exc_q   <= 1'b0;
      end else if (load) begin
         valid_q <= 1'b1;
         we_q    <= in_data.prf_we;
         fls_q   <= in_data.fls;
         exc_q   <= in_data.exc;
      end else if (out_ready) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         data_q <= in_data;
      end
   end

   // Payload from the data register, control bits from the cleared flops
   always_comb begin
      out_data        = data_q;
      out_data.prf_we = we_q;
      out_data.fls    = fls_q;
      out_data.exc    = exc_q;
   end

   assign out_valid = valid_q;

endmodule

//--- source/ex_pipe.sv
// ########################################
// Execute pipe top level
// Shared adder, address path, prediction
// check, result mux and output stage
// ########################################

`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_pipe
   import ex_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      flush,
   input  logic      ex_valid,
   input  ex_req_t   ex_req,
   output logic      ex_ready,
   input  logic      wb_ready,
   output logic      wb_valid,
   output ex_wb_t    wb
);

   logic                  is_bru;
   logic                  is_rf_unit;
   logic                  agu_en;
   logic                  add_s;
   logic [`EX_DW-1:0]     add_b;
   logic [`EX_DW-1:0]     add_bx;
   logic [`EX_DW:0]       add_full;
   logic [`EX_DW-1:0]     add_sum;
   logic                  carry;
   logic                  overflow;
   logic [`EX_PC_W-1:0]   npc;
   logic [`EX_DW-1:0]     alu_result;
   logic                  taken;
   logic [`EX_PC_W-1:0]   tgt;
   logic [`EX_DW-1:0]     link;
   logic                  mispred;
   logic [`EX_DW-1:0]     redirect;
   logic                  buf_load;
   ex_wb_t                wb_next;

   assign is_bru     = (ex_req.unit == UNIT_BRU);
   assign is_rf_unit = (ex_req.unit == UNIT_ALU) | is_bru;

   // Load/store and exception ops only form an address here
   assign agu_en = (ex_req.unit == UNIT_LSU) | (ex_req.unit == UNIT_EPU);

   // Subtract for compares and conditional branches
   always_comb begin
      case (ex_req.unit)
         UNIT_ALU: add_s = ex_req.op.alu inside {ALU_SUB, ALU_SLT, ALU_SLTU};
         UNIT_BRU: add_s = !(ex_req.op.bru inside {BRU_JAL, BRU_JALR});
         default:  add_s = 1'b0;
      endcase
   end

   // Shared adder, a - b done as a + ~b + 1
   assign add_b    = agu_en ? ex_req.imm : ex_req.operand2;
   assign add_bx   = add_b ^ {`EX_DW{add_s}};
   assign add_full = {1'b0, ex_req.operand1} + {1'b0, add_bx} + {{`EX_DW{1'b0}}, add_s};
   assign add_sum  = add_full[`EX_DW-1:0];
   assign carry    = add_full[`EX_DW];
   assign overflow = (ex_req.operand1[`EX_DW-1] == add_bx[`EX_DW-1]) &
                     (add_sum[`EX_DW-1] != ex_req.operand1[`EX_DW-1]);

   assign npc = ex_req.pc + `EX_PC_W'(1);

   ex_alu i_alu (
      .op          (ex_req.op.alu),
      .operand1    (ex_req.operand1),
      .operand2    (ex_req.operand2),
      .imm         (ex_req.imm),
      .add_sum     (add_sum),
      .carry       (carry),
      .overflow    (overflow),
      .alu_result  (alu_result)
   );

   ex_bru i_bru (
      .op          (ex_req.op.bru),
      .pc          (ex_req.pc),
      .npc         (npc),
      .imm         (ex_req.imm),
      .operand1    (ex_req.operand1),
      .add_sum     (add_sum),
      .carry       (carry),
      .overflow    (overflow),
      .taken       (taken),
      .tgt         (tgt),
      .link        (link)
   );

   // Wrong direction, or right direction to the wrong place
   assign mispred = (taken != ex_req.pred_taken) |
                    (taken & (tgt != ex_req.pred_tgt));

   // Byte address where fetch must restart
   assign redirect = taken ? {tgt, 2'b00} : {npc, 2'b00};

   always_comb begin
      wb_next.rob_id    = ex_req.rob_id;
      wb_next.prf_waddr = ex_req.prd;
      wb_next.prf_wdata = is_bru ? link : alu_result;
      // Control bits only qualified on an accepted op
      wb_next.prf_we    = buf_load & ex_req.prd_we & is_rf_unit;
      wb_next.fls       = buf_load & is_bru & mispred;
      wb_next.exc       = buf_load & (|ex_req.fe);
      if (wb_next.fls) begin
         wb_next.opera = redirect;
      end else if (wb_next.exc) begin
         wb_next.opera = {{(`EX_DW-`EX_FE_W){1'b0}}, ex_req.fe};
      end else begin
         wb_next.opera = add_sum;
      end
      wb_next.operb     = ex_req.operand2;
   end

   ex_out_buf i_out_buf (
      .clk        (clk),
      .arst_n     (arst_n),
      .flush      (flush),
      .in_valid   (ex_valid),
      .out_ready  (wb_ready),
      .in_data    (wb_next),
      .in_ready   (ex_ready),
      .out_valid  (wb_valid),
      .load       (buf_load),
      .out_data   (wb)
   );

endmodule

//--- bench/ex_tb_model.svh
// ########################################
// Reference model of the execute pipe
// Expected writeback record per request
// ########################################

`ifndef EX_TB_MODEL_SVH
`define EX_TB_MODEL_SVH

// Adder output, also the address of lsu and epu ops
function automatic logic [`EX_DW-1:0] adder_value(ex_req_t req);
   case (req.unit)
      UNIT_ALU: begin
         if (req.op.alu inside {ALU_SUB, ALU_SLT, ALU_SLTU}) begin
            return req.operand1 - req.operand2;
         end
         return req.operand1 + req.operand2;
      end
      UNIT_BRU: begin
         if (req.op.bru inside {BRU_JAL, BRU_JALR}) begin
            return req.operand1 + req.operand2;
         end
         return req.operand1 - req.operand2;
      end
      default: return req.operand1 + req.imm;
   endcase
endfunction

function automatic logic [`EX_DW-1:0] alu_value(ex_req_t req);
   logic [4:0] sh;
   sh = req.operand2[4:0];
   case (req.op.alu)
      ALU_ADD, ALU_SUB: return adder_value(req);
      ALU_AND:  return req.operand1 & req.operand2;
      ALU_OR:   return req.operand1 | req.operand2;
      ALU_XOR:  return req.operand1 ^ req.operand2;
      ALU_SLL:  return req.operand1 << sh;
      ALU_SRL:  return req.operand1 >> sh;
      ALU_SRA:  return $unsigned($signed(req.operand1) >>> sh);
      ALU_SLT:  return `EX_DW'($signed(req.operand1) < $signed(req.operand2));
      ALU_SLTU: return `EX_DW'(req.operand1 < req.operand2);
      ALU_MOVI: return req.imm;
      default:  return '0;
   endcase
endfunction

function automatic logic branch_taken(ex_req_t req);
   case (req.op.bru)
      BRU_BEQ:  return req.operand1 == req.operand2;
      BRU_BNE:  return req.operand1 != req.operand2;
      BRU_BLT:  return $signed(req.operand1) < $signed(req.operand2);
      BRU_BGE:  return $signed(req.operand1) >= $signed(req.operand2);
      BRU_BLTU: return req.operand1 < req.operand2;
      BRU_BGEU: return req.operand1 >= req.operand2;
      default:  return 1'b1;
   endcase
endfunction

// Word target, jalr drops the two byte bits
function automatic logic [`EX_PC_W-1:0] branch_target(ex_req_t req);
   if (req.op.bru == BRU_JALR) begin
      return `EX_PC_W'(req.operand1 >> 2);
   end
   return req.pc + req.imm[`EX_PC_W-1:0];
endfunction

function automatic ex_wb_t expect_record(ex_req_t req);
   ex_wb_t               rec;
   logic [`EX_PC_W-1:0]  npc;
   logic                 tk;
   logic [`EX_PC_W-1:0]  tg;
   npc = req.pc + `EX_PC_W'(1);
   tk  = branch_taken(req);
   tg  = branch_target(req);
   rec.rob_id    = req.rob_id;
   rec.prf_waddr = req.prd;
   rec.prf_we    = req.prd_we && (req.unit == UNIT_ALU || req.unit == UNIT_BRU);
   rec.prf_wdata = (req.unit == UNIT_BRU) ? {npc, 2'b00} : alu_value(req);
   rec.fls       = (req.unit == UNIT_BRU) &&
                   ((tk != req.pred_taken) || (tk && tg != req.pred_tgt));
   rec.exc       = (req.fe != '0);
   if (rec.fls) begin
      rec.opera = tk ? {tg, 2'b00} : {npc, 2'b00};
   end else if (rec.exc) begin
      rec.opera = `EX_DW'(req.fe);
   end else begin
      rec.opera = adder_value(req);
   end
   rec.operb = req.operand2;
   return rec;
endfunction

`endif

//--- bench/ex_pipe_tb.sv
// ########################################
// Testbench for the execute pipe
// Clock, reset, random requests, queue
// scoreboard and output assertions
// ########################################

`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_pipe_tb
   import ex_pkg::*;
();

   localparam int N_REQ      = 2000;
   localparam int MAX_CYCLES = N_REQ * 4;

   logic          clk;
   logic          arst_n;
   logic          flush;
   logic          ex_valid;
   logic          ex_ready;
   logic          wb_ready;
   logic          wb_valid;
   ex_req_t       ex_req;
   ex_wb_t        wb;
   logic [31:0]   lcg_state;
   ex_wb_t        exp_q[$];
   ex_wb_t        exp_head;
   int            exp_cnt;
   int            n_accepted;

`include "ex_tb_model.svh"

   ex_pipe i_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .flush     (flush),
      .ex_valid  (ex_valid),
      .ex_req    (ex_req),
      .ex_ready  (ex_ready),
      .wb_ready  (wb_ready),
      .wb_valid  (wb_valid),
      .wb        (wb)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Sign boundaries and small values now and then
   function automatic logic [`EX_DW-1:0] pick_operand(logic [31:0] r);
      case (r[2:0])
         3'd0:    return 32'h8000_0000;
         3'd1:    return 32'h7fff_ffff;
         3'd2:    return 32'hffff_ffff;
         3'd3:    return {27'd0, r[7:3]};
         default: return next_rand();
      endcase
   endfunction

   task automatic make_req(output ex_req_t req);
      logic [31:0] r;
      r = next_rand();
      req = '0;
      req.unit       = ex_unit_e'(r[31:30]);
      req.fe         = (r[29:27] == 3'd0) ? r[26:23] : '0;
      req.pred_taken = r[22];
      req.prd_we     = r[21];
      req.prd        = r[16:11];
      req.rob_id     = r[10:6];
      case (req.unit)
         UNIT_ALU: req.op.alu = ex_alu_op_e'(4'(next_rand() % 32'd11));
         UNIT_BRU: req.op.bru = ex_bru_op_e'(4'(next_rand() % 32'd8));
         default:  req.op.alu = ALU_ADD;
      endcase
      req.pc       = `EX_PC_W'(next_rand());
      req.imm      = next_rand();
      req.operand1 = pick_operand(next_rand());
      req.operand2 = (r[20:18] == 3'd0) ? req.operand1 : pick_operand(next_rand());
      // Half the predictions carry the right target
      req.pred_tgt = r[17] ? branch_target(req) : `EX_PC_W'(next_rand());
   endtask

   task automatic stop_on_error(string what);
      $display("%s", what);
      $display("Some tests failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic report_mismatch(string name, logic [127:0] got, logic [127:0] exp);
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      stop_on_error("DUT output differs from the reference model");
   endtask

   task automatic check_reset_state();
      assert (!wb_valid && !wb.prf_we && !wb.fls && !wb.exc)
         else stop_on_error("wb_valid or a record control bit is set after reset");
   endtask

   // Scoreboard, one record per accepted request in order
   always @(posedge clk) begin
      if (!arst_n) begin
         exp_q.delete();
         exp_cnt    <= 0;
         exp_head   <= '0;
         n_accepted <= 0;
      end else begin
         if (wb_valid && (wb_ready || flush) && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
         end
         if (ex_valid && ex_ready) begin
            n_accepted <= n_accepted + 1;
            // Flush on the same edge drops the new record too
            if (!flush) begin
               exp_q.push_back(expect_record(ex_req));
            end
         end
         exp_cnt <= exp_q.size();
         if (exp_q.size() != 0) begin
            exp_head <= exp_q[0];
         end else begin
            exp_head <= '0;
         end
      end
   end

   a_wdata: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_valid && wb_ready) |-> (wb.prf_wdata == exp_head.prf_wdata))
      else report_mismatch("wb.prf_wdata", 128'($sampled(wb.prf_wdata)),
                           128'($sampled(exp_head.prf_wdata)));
   a_opera: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_valid && wb_ready) |-> (wb.opera == exp_head.opera))
      else report_mismatch("wb.opera", 128'($sampled(wb.opera)),
                           128'($sampled(exp_head.opera)));
   a_record: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_valid && wb_ready) |-> (wb == exp_head))
      else report_mismatch("wb", 128'($sampled(wb)), 128'($sampled(exp_head)));
   a_ready: assert property (@(posedge clk) disable iff (!arst_n)
      ex_ready == (!wb_valid || wb_ready))
      else report_mismatch("ex_ready", 128'($sampled(ex_ready)),
                           128'($sampled(!wb_valid || wb_ready)));
   // Record shows up on the cycle right after acceptance
   a_latency: assert property (@(posedge clk) disable iff (!arst_n)
      (ex_valid && ex_ready && !flush) |=> wb_valid)
      else stop_on_error("an accepted request did not reach wb one cycle later");
   a_extra: assert property (@(posedge clk) disable iff (!arst_n)
      wb_valid |-> (exp_cnt != 0))
      else stop_on_error("wb_valid is set with no accepted request outstanding");
   a_hold: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_valid && !wb_ready && !flush) |=> (wb_valid && $stable(wb)))
      else stop_on_error("record or wb_valid changed while wb_ready was low");
   a_flush: assert property (@(posedge clk) disable iff (!arst_n)
      flush |=> !wb_valid)
      else stop_on_error("wb_valid is still set on the cycle after a flush");

   initial begin
      int n_cycles;
      n_cycles = 0;
      while (n_cycles < MAX_CYCLES) begin
         @(posedge clk);
         n_cycles++;
      end
      stop_on_error("timeout, the requests did not all complete");
   end

   initial begin
      ex_req_t      req;
      logic [31:0]  r;
      int           n_driven;
      n_driven  = 0;
      lcg_state = 32'h73c30f8a;
      arst_n    = 1'b0;
      flush     = 1'b0;
      ex_valid  = 1'b0;
      wb_ready  = 1'b0;
      ex_req    = '0;
      repeat (8) @(negedge clk);
      check_reset_state();
      arst_n = 1'b1;
      @(negedge clk);
      check_reset_state();
      while (n_accepted < N_REQ) begin
         r = next_rand();
         wb_ready = (r[31:30] != 2'b00);
         flush    = (r[29:25] == 5'd0);
         // New request only once the last one was taken
         if (n_accepted == n_driven) begin
            if (n_driven < N_REQ && r[24:22] != 3'd0) begin
               make_req(req);
               ex_req   = req;
               ex_valid = 1'b1;
               n_driven++;
            end else begin
               ex_valid = 1'b0;
            end
         end
         @(negedge clk);
      end
      ex_valid = 1'b0;
      flush    = 1'b0;
      wb_ready = 1'b1;
      repeat (4) @(negedge clk);
      if (exp_cnt != 0 || wb_valid) begin
         stop_on_error("records were left in the output stage at the end");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

//--- sim.f
+incdir+source
+incdir+bench
source/ex_pkg.sv
source/ex_alu.sv
source/ex_bru.sv
source/ex_out_buf.sv
source/ex_pipe.sv
bench/ex_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module ex_pipe_tb \
   -Mdir obj_dir -o ex_pipe_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
   cat build.log
   echo "Verilator build failed with status $build_status"
   exit 1
fi

./obj_dir/ex_pipe_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
   echo "Simulation FAILED"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "Simulator exited with status $run_status"
   exit 1
fi
echo "Simulation PASSED"
exit 0
